// File: project.f
logic/lsu_pkg.sv
logic/lsu_ifs.sv
logic/store_unit.sv
logic/lsu_decode.sv
logic/lsu_execute.sv
logic/data_ram.sv
logic/lsu_result.sv
logic/lsu_top.sv
verification/lsu_props.sv
verification/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lsu testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module lsu_tb \
  -Mdir "${BUILD_DIR}" \
  -f project.f

"./${BUILD_DIR}/Vlsu_tb" | tee "${LOG}"

# the testbench prints its verdict, a missing verdict counts as failure
if grep -q "Test FAILED" "${LOG}"; then
  echo "simulation failed, see ${LOG}"
  exit 1
fi
if ! grep -q "Test OK" "${LOG}"; then
  echo "simulation ended without a verdict, see ${LOG}"
  exit 1
fi
echo "simulation passed"

// File: verification/lsu_tb.sv
//======================================================================
// lsu testbench
// drives loads, stores and faulting ops into the load/store path and
// checks every completion against a byte-wide shadow memory
//======================================================================

`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 16;
  localparam int    MEM_WORDS    = 256;
  localparam int    FILL_WORDS   = 16;
  localparam int    RAND_OPS     = 64;
  // fill, size and offset sweep, illegal ops, random mix
  localparam int    NUM_OPS      = FILL_WORDS + 12 * 7 + 11 + RAND_OPS;
  // random gaps add at most one idle cycle per random op
  localparam int    WATCHDOG_CYC = RESET_CYCLES + NUM_OPS + RAND_OPS + 32;
  // test region and the base register pointing past it
  localparam word_t BASE         = 32'h0000_0100;
  localparam word_t PTR          = BASE + 32'h40;

  localparam funct3_t STORE_F3 [3] = '{F3_B, F3_H, F3_W};
  localparam funct3_t LOAD_F3  [5] = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};

  typedef struct packed {
    logic  mis;
    logic  ill;
    word_t data;
  } expect_t;

  logic  clk;
  logic  rst_n;
  logic  valid;
  word_t instr;
  word_t rs1;
  word_t rs2;
  logic  done;
  logic  misaligned;
  logic  illegal;
  word_t load_data;

  logic [7:0] shadow [MEM_WORDS * 4];
  expect_t    exp_q [$];
  expect_t    got_exp;
  int         seed = 61;
  int         data_errs = 0;
  int         flag_errs = 0;
  int         proto_errs = 0;

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .valid_i      (valid),
    .instr_i      (instr),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .done_o       (done),
    .misaligned_o (misaligned),
    .illegal_o    (illegal),
    .load_data_o  (load_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //======================================================================
  // reference model
  //======================================================================

  function automatic word_t encode_load(input funct3_t f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, OPC_LOAD};
  endfunction

  function automatic word_t encode_store(input funct3_t f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  // wraps like the RAM does
  function automatic int byte_index(input word_t a, input int k);
    word_t t;
    t = a + k;
    return int'(t % (MEM_WORDS * 4));
  endfunction

  function automatic word_t fill_word(input word_t a);
    return a * 32'h9e37_79b9 + 32'h1357_9bdf;
  endfunction

  // drive one op and queue what the RV32I rules say it must return
  task automatic issue_op(input word_t instr_w, input word_t base, input word_t data);
    logic [6:0] opc;
    funct3_t    f3;
    int         nbytes;
    logic       is_ld;
    logic       is_st;
    word_t      imm;
    word_t      addr;
    word_t      val;
    expect_t    e;
    @(negedge clk);
    valid = 1'b1;
    instr = instr_w;
    rs1   = base;
    rs2   = data;
    opc    = instr_w[6:0];
    f3     = instr_w[14:12];
    nbytes = 1 << f3[1:0];
    is_ld  = (opc == OPC_LOAD) && (f3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
    is_st  = (opc == OPC_STORE) && (f3 inside {F3_B, F3_H, F3_W});
    // S-type splits the immediate around rd
    imm  = is_st ? {{20{instr_w[31]}}, instr_w[31:25], instr_w[11:7]}
                 : {{20{instr_w[31]}}, instr_w[31:20]};
    addr = base + imm;
    e.ill  = !(is_ld || is_st);
    e.mis  = !e.ill && ((nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00));
    e.data = '0;
    if (is_st && !e.mis) begin
      for (int k = 0; k < nbytes; k++) begin
        shadow[byte_index(addr, k)] = data[8*k +: 8];
      end
    end
    if (is_ld && !e.mis) begin
      val = '0;
      for (int k = 0; k < nbytes; k++) begin
        val[8*k +: 8] = shadow[byte_index(addr, k)];
      end
      // funct3 bit 2 selects zero extension
      if (nbytes == 1 && !f3[2]) val = {{24{val[7]}}, val[7:0]};
      if (nbytes == 2 && !f3[2]) val = {{16{val[15]}}, val[15:0]};
      e.data = val;
    end
    exp_q.push_back(e);
  endtask

  // offset is relative to BASE, reached with a negative immediate from PTR
  task automatic access_mem(input logic store, input funct3_t f3, input word_t offset,
                            input word_t data);
    word_t rel;
    rel = offset - 32'h40;
    issue_op(store ? encode_store(f3, rel[11:0]) : encode_load(f3, rel[11:0]), PTR, data);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    valid = 1'b0;
  endtask

  //======================================================================
  // completion checker
  //======================================================================

  always @(negedge clk) begin
    if (rst_n && done) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("done_o pulsed with no operation outstanding at %0t", $time);
      end else begin
        got_exp = exp_q.pop_front();
        assert (misaligned == got_exp.mis) else begin
          flag_errs++;
          $display("** Error: misaligned_o = %h, expected %h", misaligned, got_exp.mis);
        end
        assert (illegal == got_exp.ill) else begin
          flag_errs++;
          $display("** Error: illegal_o = %h, expected %h", illegal, got_exp.ill);
        end
        assert (load_data == got_exp.data) else begin
          data_errs++;
          $display("** Error: load_data_o = %h, expected %h", load_data, got_exp.data);
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("watchdog expired with %0d completions outstanding", exp_q.size());
    $display("Test FAILED");
    $finish;
  end

  //======================================================================
  // stimulus
  //======================================================================

  initial begin
    word_t r;
    word_t d;
    word_t wofs;
    clk   = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    instr = '0;
    rs1   = '0;
    rs2   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // known contents for the whole test region
    for (int w = 0; w < FILL_WORDS; w++) begin
      access_mem(1'b1, F3_W, word_t'(w * 4), fill_word(BASE + word_t'(w * 4)));
    end

    // every store size at every offset, then every load kind right behind it
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        wofs = word_t'((4 + s * 4 + off) * 4 + off);
        access_mem(1'b1, STORE_F3[s], wofs, $random(seed));
        for (int l = 0; l < 5; l++) begin
          access_mem(1'b0, LOAD_F3[l], wofs, '0);
        end
        // whole word shows whether a misaligned store left it alone
        access_mem(1'b0, F3_W, wofs & ~32'h3, '0);
      end
    end

    // unsigned or reserved store sizes, each followed by a readback
    access_mem(1'b1, F3_BU, 32'h0c, $random(seed));
    access_mem(1'b0, F3_W, 32'h0c, '0);
    access_mem(1'b1, F3_HU, 32'h0c, $random(seed));
    access_mem(1'b0, F3_W, 32'h0c, '0);
    access_mem(1'b1, 3'b011, 32'h0c, $random(seed));
    access_mem(1'b0, F3_W, 32'h0c, '0);
    access_mem(1'b0, 3'b011, 32'h0c, '0);
    access_mem(1'b0, 3'b110, 32'h0c, '0);
    access_mem(1'b0, 3'b111, 32'h0c, '0);
    // OP-IMM and OP opcodes
    issue_op({12'h004, 5'd1, 3'b000, 5'd2, 7'b0010011}, PTR, 32'hffff_ffff);
    issue_op({7'b0000000, 5'd3, 5'd1, 3'b000, 5'd2, 7'b0110011}, PTR, 32'hffff_ffff);

    // random mix with occasional gaps
    for (int n = 0; n < RAND_OPS; n++) begin
      r = $random(seed);
      d = $random(seed);
      if (r[31]) idle_cycle();
      if (r[8]) begin
        access_mem(1'b1, STORE_F3[int'(r[10:9]) % 3], {26'b0, r[5:0]}, d);
      end else begin
        access_mem(1'b0, LOAD_F3[int'(r[13:11]) % 5], {26'b0, r[5:0]}, '0);
      end
    end

    idle_cycle();
    while (exp_q.size() != 0) @(negedge clk);
    // a few more cycles to catch a stray completion
    repeat (4) @(negedge clk);

    $display("errors: data %0d, flags %0d, protocol %0d", data_errs, flag_errs, proto_errs);
    if (data_errs + flag_errs + proto_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verification/lsu_props.sv
//======================================================================
// lsu properties
// latency, strobe and write-suppression rules of the load/store path
//======================================================================

`timescale 1ns/1ps

module lsu_props (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            valid_i,
  input logic            done_i,
  input logic            misaligned_i,
  input logic            illegal_i,
  input logic            ram_we_i,
  input lsu_pkg::wstrb_t ram_wstrb_i,
  input logic            op_illegal_i
);

  // nothing completes while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !done_i && !misaligned_i && !illegal_i)
    else $error("done or exception output high during reset");

  // every issue completes exactly three cycles later
  done_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> ##3 done_i)
    else $error("done_o missing three cycles after issue");

  // and no completion without an issue
  done_spurious: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !valid_i |-> ##3 !done_i)
    else $error("done_o without a matching issue");

  // strobes are one byte, an aligned halfword pair or the full word
  strobe_shape: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram_we_i |-> ram_wstrb_i inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                     4'b0011, 4'b1100, 4'b1111})
    else $error("RAM write with a malformed strobe pattern");

  // an illegal op in execute never writes
  write_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram_we_i |-> !op_illegal_i)
    else $error("RAM written by an illegal operation");

  // the write cycle of a faulting op sits two cycles before its done
  write_faulted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i && (misaligned_i || illegal_i) |-> !$past(ram_we_i, 2))
    else $error("RAM written by an operation that raised an exception");

endmodule

bind lsu_top lsu_props u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .valid_i      (valid_i),
  .done_i       (done_o),
  .misaligned_i (misaligned_o),
  .illegal_i    (illegal_o),
  .ram_we_i     (mem_bus.we),
  .ram_wstrb_i  (mem_bus.wstrb),
  .op_illegal_i (d2x.illegal)
);

// File: logic/lsu_top.sv
//======================================================================
// lsu top level
// decode, execute and result stages around the data RAM, three cycles
// from issue to done
//======================================================================

`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           valid_i,
  input  lsu_pkg::word_t instr_i,
  input  lsu_pkg::word_t rs1_i,
  input  lsu_pkg::word_t rs2_i,
  output logic           done_o,
  output logic           misaligned_o,
  output logic           illegal_o,
  output lsu_pkg::word_t load_data_o
);

  // decode to execute, execute to result
  lsu_op_if  d2x ();
  lsu_op_if  x2r ();
  // execute to RAM
  mem_req_if mem_bus ();

  lsu_decode u_decode (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .rs1_i   (rs1_i),
    .rs2_i   (rs2_i),
    .op_o    (d2x)
  );

  lsu_execute u_execute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .op_i    (d2x),
    .mem_o   (mem_bus),
    .op_o    (x2r)
  );

  data_ram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ram (
    .clk_i (clk_i),
    .mem_i (mem_bus)
  );

  // read data bypasses the request modport straight into result
  lsu_result u_result (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .op_i         (x2r),
    .rdata_i      (mem_bus.rdata),
    .done_o       (done_o),
    .misaligned_o (misaligned_o),
    .illegal_o    (illegal_o),
    .load_data_o  (load_data_o)
  );

endmodule

// File: logic/lsu_result.sv
//======================================================================
// lsu result stage
// picks the loaded lane out of the read word, extends it and reports
// completion and exceptions
//======================================================================

`timescale 1ns/1ps

module lsu_result (
  input  logic           clk_i,
  input  logic           rst_n_i,
  lsu_op_if.dst          op_i,
  input  lsu_pkg::word_t rdata_i,
  output logic           done_o,
  output logic           misaligned_o,
  output logic           illegal_o,
  output lsu_pkg::word_t load_data_o
);
  import lsu_pkg::*;

  word_t       shifted;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  word_t       extended;
  logic        load_ok;

  // move the addressed lane down to bit 0
  assign shifted  = rdata_i >> {op_i.addr[1:0], 3'b000};
  assign byte_sel = shifted[7:0];
  assign half_sel = shifted[15:0];

  // sign or zero extension by size
  always_comb begin
    extended = '0;
    if (op_i.size[0]) begin
      extended = op_i.is_unsigned ? {24'h000000, byte_sel}
                                  : {{24{byte_sel[7]}}, byte_sel};
    end else if (op_i.size[1]) begin
      extended = op_i.is_unsigned ? {16'h0000, half_sel}
                                  : {{16{half_sel[15]}}, half_sel};
    end else if (op_i.size[2]) begin
      extended = rdata_i;
    end
  end

  // data is only returned for a clean load
  assign load_ok = op_i.valid && op_i.is_load && !op_i.misaligned && !op_i.illegal;

  //======================================================================
  // output register
  //======================================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o       <= 1'b0;
      misaligned_o <= 1'b0;
      illegal_o    <= 1'b0;
      load_data_o  <= '0;
    end else begin
      // every valid op completes, exceptions included
      done_o       <= op_i.valid;
      misaligned_o <= op_i.valid && op_i.misaligned;
      illegal_o    <= op_i.valid && op_i.illegal;
      load_data_o  <= load_ok ? extended : '0;
    end
  end

endmodule

// File: logic/data_ram.sv
//======================================================================
// data RAM
// single-port word RAM with byte write enables and a registered read,
// word index wraps at MEM_WORDS
//======================================================================

`timescale 1ns/1ps

module data_ram #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic   clk_i,
  mem_req_if.mem mem_i
);
  import lsu_pkg::*;

  // MEM_WORDS is a power of two, so dropping upper bits is the modulo
  localparam int unsigned AW = $clog2(MEM_WORDS);

  word_t          mem [MEM_WORDS];
  logic  [AW-1:0] idx;

  assign idx = mem_i.word_addr[AW-1:0];

  //======================================================================
  // write port
  //======================================================================

  // one enable per byte lane
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (mem_i.we && mem_i.wstrb[b]) begin
        mem[idx][b*8 +: 8] <= mem_i.wdata[b*8 +: 8];
      end
    end
  end

  //======================================================================
  // read port
  //======================================================================

  // old data is returned when reading and writing the same word
  // in one cycle, a following load sees the new data
  always_ff @(posedge clk_i) begin
    mem_i.rdata <= mem[idx];
  end

endmodule

// File: logic/lsu_execute.sv
//======================================================================
// lsu execute stage
// forms the effective address, checks alignment, drives the RAM port
// and registers the operation into x2r
//======================================================================

`timescale 1ns/1ps

module lsu_execute (
  input  logic    clk_i,
  input  logic    rst_n_i,
  lsu_op_if.dst   op_i,
  mem_req_if.ctrl mem_o,
  lsu_op_if.src   op_o
);
  import lsu_pkg::*;

  word_t  addr;
  logic   misaligned_store;
  logic   misaligned_load;
  logic   misaligned;
  logic   store_ok;
  wstrb_t store_wstrb;
  word_t  store_wdata;

  // base plus immediate
  assign addr = op_i.addr + op_i.imm;

  // lane placement and strobes for stores
  store_unit u_store (
    .store_size_onehot_i (op_i.size),
    .waddr_lower2_i      (addr[1:0]),
    .wdata_unformatted_i (op_i.wdata),
    .misaligned_store_o  (misaligned_store),
    .wstrb_o             (store_wstrb),
    .wdata_o             (store_wdata)
  );

  // loads follow the same halfword and word rule
  assign misaligned_load = op_i.is_load &&
                           ((op_i.size[1] && addr[0]) || (op_i.size[2] && |addr[1:0]));

  assign misaligned = misaligned_load || (op_i.is_store && misaligned_store);

  // only a clean store may write
  assign store_ok = op_i.valid && op_i.is_store && !op_i.illegal && !misaligned_store;

  //======================================================================
  // RAM request
  //======================================================================

  // read is launched every cycle, result ignores it unless it is a load
  assign mem_o.we        = store_ok;
  assign mem_o.word_addr = addr[31:2];
  assign mem_o.wstrb     = store_ok ? store_wstrb : '0;
  assign mem_o.wdata     = store_wdata;

  //======================================================================
  // stage register
  //======================================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_o.valid      <= 1'b0;
      op_o.is_load    <= 1'b0;
      op_o.is_store   <= 1'b0;
      op_o.illegal    <= 1'b0;
      op_o.misaligned <= 1'b0;
    end else begin
      op_o.valid      <= op_i.valid;
      op_o.is_load    <= op_i.valid && op_i.is_load;
      op_o.is_store   <= op_i.valid && op_i.is_store;
      op_o.illegal    <= op_i.valid && op_i.illegal;
      op_o.misaligned <= op_i.valid && misaligned;
    end
  end

  // addr now holds the effective address
  always_ff @(posedge clk_i) begin
    op_o.size        <= op_i.size;
    op_o.is_unsigned <= op_i.is_unsigned;
    op_o.addr        <= addr;
  end

endmodule

// File: logic/lsu_decode.sv
//======================================================================
// lsu decode stage
// recognises load and store opcodes, turns funct3 into a one-hot size,
// builds the immediate and registers the operation into d2x
//======================================================================

`timescale 1ns/1ps

module lsu_decode (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           valid_i,
  input  lsu_pkg::word_t instr_i,
  input  lsu_pkg::word_t rs1_i,
  input  lsu_pkg::word_t rs2_i,
  lsu_op_if.src          op_o
);
  import lsu_pkg::*;

  logic [6:0] opcode;
  funct3_t    funct3;
  size_oh_t   size;
  logic       is_unsigned;
  logic       legal_load;
  logic       legal_store;
  word_t      imm_i_type;
  word_t      imm_s_type;

  // instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // I-type for loads, S-type for stores, both sign extended
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // funct3 to size and signedness, reserved codes give no size
  always_comb begin
    size        = '0;
    is_unsigned = 1'b0;
    case (funct3)
      F3_B:  size = 3'b001;
      F3_H:  size = 3'b010;
      F3_W:  size = 3'b100;
      F3_BU: begin
        size        = 3'b001;
        is_unsigned = 1'b1;
      end
      F3_HU: begin
        size        = 3'b010;
        is_unsigned = 1'b1;
      end
      default: size = '0;
    endcase
  end

  // stores have no unsigned forms
  assign legal_load  = (opcode == OPC_LOAD) && (size != '0);
  assign legal_store = (opcode == OPC_STORE) && (size != '0) && !is_unsigned;

  // misalignment needs the full address, execute decides it
  assign op_o.misaligned = 1'b0;

  // control bits, anything that is not a legal access is flagged illegal
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op_o.valid    <= 1'b0;
      op_o.is_load  <= 1'b0;
      op_o.is_store <= 1'b0;
      op_o.illegal  <= 1'b0;
    end else begin
      op_o.valid    <= valid_i;
      op_o.is_load  <= valid_i && legal_load;
      op_o.is_store <= valid_i && legal_store;
      op_o.illegal  <= valid_i && !(legal_load || legal_store);
    end
  end

  // payload, qualified by the control bits above
  always_ff @(posedge clk_i) begin
    op_o.size        <= (legal_load || legal_store) ? size : '0;
    op_o.is_unsigned <= is_unsigned;
    op_o.addr        <= rs1_i;
    op_o.imm         <= (opcode == OPC_STORE) ? imm_s_type : imm_i_type;
    op_o.wdata       <= rs2_i;
  end

endmodule

// File: logic/store_unit.sv
//======================================================================
// store unit
// places store data in its byte lanes, builds the byte strobes and
// flags stores whose address does not match their size
//======================================================================

`timescale 1ns/1ps

module store_unit (
  input  lsu_pkg::size_oh_t store_size_onehot_i,
  input  logic [1:0]        waddr_lower2_i,
  input  lsu_pkg::word_t    wdata_unformatted_i,
  output logic              misaligned_store_o,
  output lsu_pkg::wstrb_t   wstrb_o,
  output lsu_pkg::word_t    wdata_o
);

  // one-hot size, lowest set bit wins if the encoding is broken
  always_comb begin
    misaligned_store_o = 1'b0;
    wstrb_o            = '0;
    wdata_o            = '0;
    if (store_size_onehot_i[0]) begin
      // byte, any offset is fine
      wstrb_o = 4'b0001 << waddr_lower2_i;
      wdata_o = wdata_unformatted_i << {waddr_lower2_i, 3'b000};
    end else if (store_size_onehot_i[1]) begin
      // halfword, lane pair picked by bit 1
      misaligned_store_o = waddr_lower2_i[0];
      if (waddr_lower2_i[1]) begin
        wstrb_o = 4'b1100;
        wdata_o = {wdata_unformatted_i[15:0], 16'h0000};
      end else begin
        wstrb_o = 4'b0011;
        wdata_o = {16'h0000, wdata_unformatted_i[15:0]};
      end
    end else if (store_size_onehot_i[2]) begin
      // word, both low bits must be clear
      misaligned_store_o = |waddr_lower2_i;
      wstrb_o            = 4'b1111;
      wdata_o            = wdata_unformatted_i;
    end
    // no size: no strobes, never misaligned
  end

endmodule

// File: logic/lsu_ifs.sv
//======================================================================
// lsu interfaces
// lsu_op_if carries one memory operation from stage to stage
// mem_req_if is the single port between execute and the data RAM
//======================================================================

`timescale 1ns/1ps

interface lsu_op_if;
  import lsu_pkg::*;

  // control
  logic     valid;
  logic     is_load;
  logic     is_store;
  logic     illegal;
  logic     misaligned;
  // access shape
  size_oh_t size;
  logic     is_unsigned;
  // base value on d2x, effective address on x2r
  word_t    addr;
  word_t    imm;
  word_t    wdata;

  modport src (output valid, is_load, is_store, illegal, misaligned,
               output size, is_unsigned, addr, imm, wdata);
  modport dst (input valid, is_load, is_store, illegal, misaligned,
               input size, is_unsigned, addr, imm, wdata);
endinterface

interface mem_req_if;
  import lsu_pkg::*;

  logic        we;
  // word index, the RAM keeps only the bits it needs
  logic [29:0] word_addr;
  wstrb_t      wstrb;
  word_t       wdata;
  // registered read data, one cycle after word_addr
  word_t       rdata;

  modport ctrl (output we, word_addr, wstrb, wdata);
  modport mem  (input we, word_addr, wstrb, wdata, output rdata);
endinterface

// File: logic/lsu_pkg.sv
//======================================================================
// lsu package
// shared data-path types and rv32i load/store encodings used by
// every stage of the load/store path
//======================================================================

package lsu_pkg;

  //======================================================================
  // data-path types
  //======================================================================

  // one data word or one byte address
  typedef logic [31:0] word_t;

  // byte enables of a single word, bit n covers byte lane n
  typedef logic [3:0] wstrb_t;

  // one-hot access size
  // bit 0 byte, bit 1 halfword, bit 2 word, all zero means no access
  typedef logic [2:0] size_oh_t;

  // funct3 field of the instruction word
  typedef logic [2:0] funct3_t;

  //======================================================================
  // encodings
  //======================================================================

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 values for loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  // unsigned variants exist for loads only
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

endpackage
